// File: files.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/booth_pp_gen.sv
verilog/wallace_column.sv
verilog/wallace_half.sv
verilog/mul_stage_reg.sv
verilog/product_adder.sv
verilog/mul_unit.sv
testbench/tb_clock_gen.sv
testbench/mul_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module mul_unit_tb -f files.f \
    && ./obj_dir/Vmul_unit_tb | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: testbench/mul_unit_tb.sv
/* multiplier testbench
   random and corner requests, 64-bit reference model, latency checker, watchdog */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_unit_tb;

    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 300;
    localparam int N_CORNER     = 4 * 5 * 5;   // ops x corner x corner
    localparam int N_GAP        = 40;
    localparam int MAX_GAP      = 7;           // also used as mask
    localparam int N_INFLIGHT   = 6;
    localparam int N_RESUME     = 30;
    localparam int DRAIN_CYCLES = 6;           // latency plus quiet cycles, per phase
    localparam int REQ_COUNT    = N_RANDOM + N_CORNER + N_GAP + N_INFLIGHT + N_RESUME;
    localparam int IDLE_MAX     = 2 * RESET_CYCLES + N_GAP * MAX_GAP + 4 + 5 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = REQ_COUNT + IDLE_MAX + 20;

    typedef struct packed {
        logic [31:0]          due;     // cycle the response must show up
        logic [`MUL_XLEN-1:0] result;
    } exp_t;

    logic               mul_clk;
    logic               arst_n;
    mul_pkg::mul_req_t  req;
    mul_pkg::mul_resp_t resp;

    int   seed   = 95;
    int   cyc    = 0;
    int   errors = 0;
    int   checks = 0;
    int   gap;
    exp_t exp_q[$];   // outstanding requests, oldest first

    logic [`MUL_XLEN-1:0] corner [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                        32'h8000_0000, 32'h7fff_ffff};

    tb_clock_gen clk_i (.mul_clk(mul_clk));

    mul_unit dut_i (
        .mul_clk (mul_clk),
        .arst_n  (arst_n),
        .req     (req),
        .resp    (resp)
    );

    always @(posedge mul_clk) cyc <= cyc + 1;

    // ----------------------------------------------------------------------
    // reference model, extend to 64 bits then multiply mod 2^64
    // ----------------------------------------------------------------------
    function automatic logic [31:0] model_result(input mul_pkg::mul_op_e op,
                                                 input logic [31:0] x, input logic [31:0] y);
        longint          x_s;
        longint          y_s;
        longint unsigned x_u;
        longint unsigned y_u;
        logic [63:0]     p;
        x_s = $signed(x);
        y_s = $signed(y);
        x_u = {32'h0, x};
        y_u = {32'h0, y};
        case (op)
            mul_pkg::op_mulh:   p = x_s * y_s;
            mul_pkg::op_mulhsu: p = x_s * y_u;   // exact product fits in 64 bits
            default:            p = x_u * y_u;   // mul low word is sign agnostic
        endcase
        return (op == mul_pkg::op_mul) ? p[31:0] : p[63:32];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // drivers, all 1 ns after the rising edge
    // ----------------------------------------------------------------------
    task automatic send_req(input mul_pkg::mul_op_e op, input logic [31:0] x,
                            input logic [31:0] y);
        exp_t e;
        @(posedge mul_clk);
        #1;
        req      = '{valid: 1'b1, op: op, x: x, y: y};
        e.due    = cyc + 2;
        e.result = model_result(op, x, y);
        exp_q.push_back(e);
    endtask

    task automatic send_random();
        logic [1:0] sel;
        sel = $random(seed);
        send_req(mul_pkg::mul_op_e'(sel), $random(seed), $random(seed));
    endtask

    task automatic send_idle(input int n);
        repeat (n) begin
            @(posedge mul_clk);
            #1;
            req = '{valid: 1'b0, op: mul_pkg::op_mulh, x: $random(seed), y: $random(seed)};
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) send_idle(1);
        send_idle(2);   // nothing extra may follow
    endtask

    task automatic apply_reset(input int n);
        @(posedge mul_clk);
        #1;
        arst_n    = 1'b0;
        req.valid = 1'b0;
        exp_q.delete();  // in-flight work is dropped
        repeat (n) @(posedge mul_clk);
        #1;
        arst_n = 1'b1;
    endtask

    // ----------------------------------------------------------------------
    // response checker, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge mul_clk) begin
        if (cyc > 0) begin
            if (resp.valid !== 1'b0) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected response valid at cycle %0d, nothing outstanding", cyc);
                end else if (exp_q[0].due != cyc) begin
                    errors++;
                    $display("response at cycle %0d but the next one is due at cycle %0d",
                             cyc, exp_q[0].due);
                end else begin
                    check_value("resp.result", exp_q[0].result, resp.result);
                    exp_q.delete(0);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                errors++;
                $display("missing response at cycle %0d", cyc);
                exp_q.delete(0);
            end
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        arst_n = 1'b0;
        req    = '0;
        repeat (RESET_CYCLES) @(posedge mul_clk);
        #1;
        arst_n = 1'b1;
        send_idle(3);  // still quiet out of reset

        repeat (N_RANDOM) send_random();  // back to back
        drain();

        for (int o = 0; o < 4; o++) begin
            for (int a = 0; a < 5; a++) begin
                for (int b = 0; b < 5; b++) begin
                    send_req(mul_pkg::mul_op_e'(o[1:0]), corner[a], corner[b]);
                end
            end
        end
        drain();

        for (int n = 0; n < N_GAP; n++) begin
            send_random();
            gap = $random(seed) & MAX_GAP;
            send_idle(gap);
        end
        drain();

        repeat (N_INFLIGHT) send_random();
        apply_reset(RESET_CYCLES);
        send_idle(4);
        repeat (N_RESUME) send_random();
        drain();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/* free-running testbench clock, 10 ns period */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic mul_clk
);

    initial mul_clk = 1'b0;

    always #5 mul_clk = ~mul_clk;  // half period

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
/* two-stage booth/wallace multiplier top
   booth rows, lower wallace half, stage reg, upper half, final add */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_unit (
    input  logic               mul_clk,
    input  logic               arst_n,
    input  mul_pkg::mul_req_t  req,
    output mul_pkg::mul_resp_t resp
);

    mul_pkg::pp_cols_t           cols;
    logic [`MUL_CSA_CARRIES-1:0] corr_lo;
    logic                        corr14;
    logic                        corr15;
    logic [`MUL_HALF_COLS-1:0]   sum_lo;
    logic [`MUL_HALF_COLS-1:0]   carry_lo;
    logic [`MUL_CSA_CARRIES-1:0] chain_lo;
    mul_pkg::stage_t             stage;
    logic [`MUL_HALF_COLS-1:0]   sum_hi;
    logic [`MUL_HALF_COLS-1:0]   carry_hi;

    // ----------------------------------------------------------------------
    // stage 1, booth rows and columns 0..31
    // ----------------------------------------------------------------------
    booth_pp_gen pp_i (
        .req     (req),
        .cols    (cols),
        .corr_lo (corr_lo),
        .corr14  (corr14),
        .corr15  (corr15)
    );

    wallace_half lo_half_i (
        .cols  (cols[`MUL_HALF_COLS-1:0]),
        .cin   (corr_lo),    // row corrections enter column 0
        .sum   (sum_lo),
        .carry (carry_lo),
        .cout  (chain_lo)
    );

    mul_stage_reg stage_i (
        .mul_clk     (mul_clk),
        .arst_n      (arst_n),
        .req         (req),
        .sum_lo      (sum_lo),
        .carry_lo    (carry_lo),
        .chain_carry (chain_lo),
        .cols_hi     (cols[`MUL_COLS-1:`MUL_HALF_COLS]),
        .corr14      (corr14),
        .corr15      (corr15),
        .stage       (stage)
    );

    // ----------------------------------------------------------------------
    // stage 2, columns 32..63 and final add
    // ----------------------------------------------------------------------
    wallace_half hi_half_i (
        .cols  (stage.cols_hi),
        .cin   (stage.chain_carry),
        .sum   (sum_hi),
        .carry (carry_hi),
        .cout  ()            // beyond bit 63
    );

    product_adder add_i (
        .mul_clk  (mul_clk),
        .arst_n   (arst_n),
        .stage    (stage),
        .sum_hi   (sum_hi),
        .carry_hi (carry_hi),
        .resp     (resp)
    );

endmodule

`default_nettype wire

// File: verilog/product_adder.sv
/* final carry-propagate add and result register
   64-bit product from sums, shifted carries and corrections, hi/lo select */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module product_adder (
    input  logic                      mul_clk,
    input  logic                      arst_n,
    input  mul_pkg::stage_t           stage,
    input  logic [`MUL_HALF_COLS-1:0] sum_hi,
    input  logic [`MUL_HALF_COLS-1:0] carry_hi,  // top bit has weight 2^64, dropped
    output mul_pkg::mul_resp_t        resp
);

    mul_pkg::product_u    product;
    logic [`MUL_COLS-1:0] carry_vec;
    logic                 valid_q;
    logic [`MUL_XLEN-1:0] result_q;

    // ----------------------------------------------------------------------
    // carry-propagate add
    // ----------------------------------------------------------------------
    // column carries move up one place, corr14 fills the hole at bit 0
    assign carry_vec = {carry_hi[`MUL_HALF_COLS-2:0], stage.carry_lo, stage.corr14};

    always_comb begin
        product.full = {sum_hi, stage.sum_lo} + carry_vec
                     + {{(`MUL_COLS-1){1'b0}}, stage.corr15};
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge mul_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage.valid;
        end
    end

    always_ff @(posedge mul_clk) begin
        if (stage.valid) begin  // hold last result when idle
            result_q <= stage.hi_sel ? product.half.hi : product.half.lo;
        end
    end

    assign resp = '{valid: valid_q, result: result_q};

endmodule

`default_nettype wire

// File: verilog/mul_stage_reg.sv
/* pipeline register between the two wallace halves
   lower-half results, upper columns, late corrections, valid and word select */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_stage_reg (
    input  logic                                        mul_clk,
    input  logic                                        arst_n,
    input  mul_pkg::mul_req_t                           req,
    input  logic [`MUL_HALF_COLS-1:0]                   sum_lo,
    input  logic [`MUL_HALF_COLS-1:0]                   carry_lo,
    input  logic [`MUL_CSA_CARRIES-1:0]                 chain_carry,
    input  logic [`MUL_HALF_COLS-1:0][`MUL_PP_ROWS-1:0] cols_hi,
    input  logic                                        corr14,
    input  logic                                        corr15,
    output mul_pkg::stage_t                             stage
);

    logic                                        valid_q;
    logic                                        hi_sel_q;
    logic [`MUL_HALF_COLS-1:0]                   sum_lo_q;
    logic [`MUL_HALF_COLS-1:0]                   carry_lo_q;
    logic [`MUL_CSA_CARRIES-1:0]                 chain_q;
    logic [`MUL_HALF_COLS-1:0][`MUL_PP_ROWS-1:0] cols_hi_q;
    logic                                        corr14_q;
    logic                                        corr15_q;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    always_ff @(posedge mul_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // payload, free running
    always_ff @(posedge mul_clk) begin
        hi_sel_q   <= (req.op != mul_pkg::op_mul);  // op ends here
        sum_lo_q   <= sum_lo;
        carry_lo_q <= carry_lo;
        chain_q    <= chain_carry;
        cols_hi_q  <= cols_hi;
        corr14_q   <= corr14;   // goes into carry vector bit 0
        corr15_q   <= corr15;   // added at the lsb
    end

    assign stage = '{valid:       valid_q,
                     hi_sel:      hi_sel_q,
                     sum_lo:      sum_lo_q,
                     carry_lo:    carry_lo_q,
                     cols_hi:     cols_hi_q,
                     chain_carry: chain_q,
                     corr14:      corr14_q,
                     corr15:      corr15_q};

endmodule

`default_nettype wire

// File: verilog/wallace_half.sv
/* chain of 32 wallace columns
   sideways carries run from column to column, sums and carries collected */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module wallace_half (
    input  logic [`MUL_HALF_COLS-1:0][`MUL_PP_ROWS-1:0] cols,
    input  logic [`MUL_CSA_CARRIES-1:0]                 cin,    // into lowest column
    output logic [`MUL_HALF_COLS-1:0]                   sum,
    output logic [`MUL_HALF_COLS-1:0]                   carry,
    output logic [`MUL_CSA_CARRIES-1:0]                 cout    // out of highest column
);

    // chain[j] feeds column j, chain[j+1] leaves it
    logic [`MUL_CSA_CARRIES-1:0] chain [`MUL_HALF_COLS+1];

    assign chain[0] = cin;

    // ----------------------------------------------------------------------
    // column array
    // ----------------------------------------------------------------------
    for (genvar j = 0; j < `MUL_HALF_COLS; j++) begin : g_col
        wallace_column col_i (
            .bits_in (cols[j]),
            .cin     (chain[j]),
            .sum     (sum[j]),
            .carry   (carry[j]),    // weight 2^(j+1), shifted at the adder
            .cout    (chain[j+1])
        );
    end

    assign cout = chain[`MUL_HALF_COLS];  // to the next half, via stage reg

endmodule

`default_nettype wire

// File: verilog/wallace_column.sv
/* one 17-input wallace column
   full-adder tree with 14 sideways carries in and out */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module wallace_column (
    input  logic [`MUL_PP_ROWS-1:0]     bits_in,
    input  logic [`MUL_CSA_CARRIES-1:0] cin,      // from column j-1, per level
    output logic                        sum,
    output logic                        carry,    // weight of next column
    output logic [`MUL_CSA_CARRIES-1:0] cout      // to column j+1, per level
);

    // 3:2 compressor, returns {carry, sum}
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        fa = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // per-level inputs and sums
    logic [14:0] l1;
    logic [4:0]  s1;
    logic [11:0] l2;
    logic [3:0]  s2;
    logic [7:0]  l3;
    logic [1:0]  s3;
    logic [5:0]  l4;
    logic [1:0]  s4;
    logic [3:0]  l5;
    logic        s5;
    logic [2:0]  l6;

    // ----------------------------------------------------------------------
    // 17 -> 2 tree, 15 full adders over six levels
    // ----------------------------------------------------------------------
    always_comb begin
        // level 1, five adders on the top 15 bits
        l1 = bits_in[16:2];
        for (int k = 0; k < 5; k++) begin
            {cout[k], s1[k]} = fa(l1[3*k], l1[3*k+1], l1[3*k+2]);
        end

        // level 2, 5 sums + 2 spare bits + 5 level-1 carries
        l2 = {cin[4:0], s1, bits_in[1:0]};
        for (int k = 0; k < 4; k++) begin
            {cout[5+k], s2[k]} = fa(l2[3*k], l2[3*k+1], l2[3*k+2]);
        end

        // level 3, two adders, cin[8:7] ride along
        l3 = {cin[8:5], s2};
        for (int k = 0; k < 2; k++) begin
            {cout[9+k], s3[k]} = fa(l3[3*k], l3[3*k+1], l3[3*k+2]);
        end

        // level 4
        l4 = {cin[10:9], l3[7:6], s3};
        for (int k = 0; k < 2; k++) begin
            {cout[11+k], s4[k]} = fa(l4[3*k], l4[3*k+1], l4[3*k+2]);
        end

        // level 5, one adder, one bit left over
        l5 = {cin[12:11], s4};
        {cout[13], s5} = fa(l5[0], l5[1], l5[2]);

        // level 6, final pair for the cpa
        l6 = {cin[13], l5[3], s5};
        {carry, sum} = fa(l6[0], l6[1], l6[2]);
    end

endmodule

`default_nettype wire

// File: verilog/booth_pp_gen.sv
/* radix-4 booth partial-product generator
   operand extension per op, 17 recoded rows, transpose into columns */

`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module booth_pp_gen (
    input  mul_pkg::mul_req_t        req,
    output mul_pkg::pp_cols_t        cols,
    output logic [`MUL_CSA_CARRIES-1:0] corr_lo,  // rows 0..13, into column 0 chain
    output logic                     corr14,
    output logic                     corr15
);

    logic                    x_sgn;        // x treated as signed
    logic                    y_sgn;        // y treated as signed
    logic [`MUL_COLS-1:0]    x_ext;
    logic [`MUL_XLEN+2:0]    y_b;          // {ext, ext, y, 0}
    logic [`MUL_COLS-1:0]    rows [`MUL_PP_ROWS];
    logic [`MUL_PP_ROWS-1:0] neg;          // row was inverted, +1 owed

    // ----------------------------------------------------------------------
    // operand extension
    // ----------------------------------------------------------------------
    assign x_sgn = (req.op == mul_pkg::op_mulh) || (req.op == mul_pkg::op_mulhsu);
    assign y_sgn = (req.op == mul_pkg::op_mulh);  // mulhsu keeps y unsigned

    assign x_ext = {{`MUL_XLEN{req.x[`MUL_XLEN-1] & x_sgn}}, req.x};
    assign y_b   = {{2{req.y[`MUL_XLEN-1] & y_sgn}}, req.y, 1'b0};

    // ----------------------------------------------------------------------
    // booth recoding, one row per digit pair
    // ----------------------------------------------------------------------
    always_comb begin : booth_rows
        logic [2:0]           dig;
        logic [`MUL_COLS-1:0] x_sh;
        logic [`MUL_COLS-1:0] mag;
        logic                 one;
        logic                 two;
        for (int i = 0; i < `MUL_PP_ROWS; i++) begin
            dig  = y_b[2*i +: 3];
            x_sh = x_ext << (2*i);                        // row weight 4^i
            one  = dig[1] ^ dig[0];                       // +-x
            two  = (dig == 3'b011) || (dig == 3'b100);    // +-2x
            mag  = one ? x_sh : (two ? (x_sh << 1) : '0);
            // 111 is a zero digit, kept positive
            neg[i]  = dig[2] & ~(dig[1] & dig[0]);
            rows[i] = neg[i] ? ~mag : mag;  // ones complement, +1 via corr
        end
    end

    // top digit only sees extension bits, never negative,
    // so neg[16] needs no correction path
    assign corr_lo = neg[`MUL_CSA_CARRIES-1:0];
    assign corr14  = neg[14];
    assign corr15  = neg[15];

    // ----------------------------------------------------------------------
    // transpose rows into wallace columns
    // ----------------------------------------------------------------------
    always_comb begin
        for (int j = 0; j < `MUL_COLS; j++) begin
            for (int i = 0; i < `MUL_PP_ROWS; i++) begin
                cols[j][i] = rows[i][j];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mul_pkg.sv
/* multiplier types
   operation enum, request/response, pipeline stage and product word */

`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    typedef enum logic [1:0] {
        op_mul    = 2'b00,  // low word
        op_mulh   = 2'b01,  // signed x signed, high word
        op_mulhsu = 2'b10,  // signed x unsigned, high word
        op_mulhu  = 2'b11   // unsigned x unsigned, high word
    } mul_op_e;

    typedef struct packed {
        logic                 valid;  // one-cycle strobe
        mul_op_e              op;
        logic [`MUL_XLEN-1:0] x;      // multiplicand
        logic [`MUL_XLEN-1:0] y;      // multiplier, booth recoded
    } mul_req_t;

    // column-major partial products, [col][row]
    typedef logic [`MUL_COLS-1:0][`MUL_PP_ROWS-1:0] pp_cols_t;

    typedef struct packed {
        logic                                          valid;
        logic                                          hi_sel;       // high word wanted
        logic [`MUL_HALF_COLS-1:0]                     sum_lo;
        logic [`MUL_HALF_COLS-1:0]                     carry_lo;
        logic [`MUL_HALF_COLS-1:0][`MUL_PP_ROWS-1:0]   cols_hi;      // untouched upper cols
        logic [`MUL_CSA_CARRIES-1:0]                   chain_carry;  // out of column 31
        logic                                          corr14;
        logic                                          corr15;
    } stage_t;

    typedef union packed {
        logic [`MUL_COLS-1:0] full;
        struct packed {
            logic [`MUL_XLEN-1:0] hi;
            logic [`MUL_XLEN-1:0] lo;
        } half;
    } product_u;

    typedef struct packed {
        logic                 valid;
        logic [`MUL_XLEN-1:0] result;
    } mul_resp_t;

endpackage

`default_nettype wire

// File: verilog/mul_defines.svh
/* width and array-size macros for the booth/wallace multiplier
   operand, partial-product, column and chain-carry counts */

`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand width, rv32 register
`define MUL_XLEN 32

// radix-4 booth rows, xlen/2 + 1 to cover the extension bits
`define MUL_PP_ROWS 17

// full product width
`define MUL_COLS 64

// columns reduced per pipeline stage
`define MUL_HALF_COLS 32

// carries passed sideways between neighbouring wallace columns
`define MUL_CSA_CARRIES 14

`endif
